// ==== filelist.f ====
design/stepper_pkg.sv
design/io_register.sv
design/periph_decode.sv
design/spi_master.sv
design/step_ramp.sv
design/stepper_periph.sv
tests/stepper_tb.sv

// ==== tests/stepper_tb.sv ====
`timescale 1ns/1ps

module stepper_tb;

  localparam int CLK_DIV      = 4;
  localparam int START_PERIOD = 40;
  localparam int MIN_PERIOD   = 8;
  localparam int RAMP         = 4;
  localparam int SPI_BITS     = 40;
  localparam int REG_OPS      = 80;
  localparam int SPI_FRAMES   = 5;
  localparam int MOVES        = 6;

  // worst-case lengths in clock cycles
  localparam int BUS_CYCLES   = 4;
  localparam int FRAME_CYCLES = 2 * CLK_DIV * SPI_BITS + 20 * BUS_CYCLES + 4 * CLK_DIV;
  localparam int MOVE_CYCLES  = 20 * START_PERIOD + 10 * BUS_CYCLES;
  localparam int LIMIT_CYCLES = 8 + 20 * BUS_CYCLES + REG_OPS * 2 * BUS_CYCLES
                                + SPI_FRAMES * FRAME_CYCLES + MOVES * MOVE_CYCLES + 500;

  logic                  clk_in;
  logic                  rst_n;
  stepper_pkg::bus_req_t req;
  stepper_pkg::bus_rsp_t rsp;
  logic [7:0]            leds;
  logic                  miso;
  logic                  sck;
  logic                  mosi;
  logic [11:0]           cs_n;
  logic                  step;

  logic [31:0] lfsr;
  logic [31:0] shadow [0:9];
  logic [39:0] rx_model;
  logic [11:0] cs_expect;
  logic        cs_seen;
  int          sck_rises;
  int          cycle_count;
  int          step_times[$];

  stepper_periph #(
    .CLK_DIV     (CLK_DIV),
    .START_PERIOD(START_PERIOD),
    .MIN_PERIOD  (MIN_PERIOD),
    .RAMP        (RAMP)
  ) dut0 (
    .clk_in(clk_in),
    .rst_n (rst_n),
    .req   (req),
    .rsp   (rsp),
    .leds  (leds),
    .miso  (miso),
    .sck   (sck),
    .mosi  (mosi),
    .cs_n  (cs_n),
    .step  (step)
  );

  // spi loopback
  assign miso = mosi;

  always #50 clk_in = ~clk_in;

  always @(posedge sck) sck_rises++;

  // step pulse times and chip-select watch
  always @(negedge clk_in) begin
    cycle_count++;
    if (step === 1'b1) begin
      step_times.push_back(cycle_count);
    end
    if (rst_n === 1'b1 && cs_n !== 12'hfff) begin
      cs_seen = 1'b1;
      assert (cs_n === cs_expect) else begin
        report_error($sformatf("MISMATCH cs_n got 0x%0h expected 0x%0h", cs_n, cs_expect));
      end
    end
  end

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp) else begin
      report_error($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] addr_of(input int idx);
    return stepper_pkg::periph_base + 32'(idx * 4);
  endfunction

  // bits a write can change
  function automatic logic [31:0] write_mask(input int idx);
    case (idx)
      stepper_pkg::reg_leds, stepper_pkg::reg_spi_tx_upper, stepper_pkg::reg_spi_tx_lower,
      stepper_pkg::reg_angle_ctrl_upper, stepper_pkg::reg_angle_ctrl_lower: return 32'hffff_ffff;
      stepper_pkg::reg_spi_config: return 32'h0000_001f;
      default: return 32'h0;
    endcase
  endfunction

  // status words assume both engines idle when read
  function automatic logic [31:0] expect_word(input int idx);
    case (idx)
      stepper_pkg::reg_spi_rx_upper: return {24'h0, rx_model[39:32]};
      stepper_pkg::reg_spi_rx_lower: return rx_model[31:0];
      stepper_pkg::reg_spi_status, stepper_pkg::reg_angle_status: return 32'h1;
      default: return shadow[idx];
    endcase
  endfunction

  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata);
    int cycles;
    cycles = 0;
    @(posedge clk_in);
    req <= '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
    do begin
      @(negedge clk_in);
      cycles++;
    end while (rsp.ready !== 1'b1);
    rdata = rsp.rdata;
    check_value("ready latency", cycles, 2);
    @(posedge clk_in);
    req <= '0;
    @(negedge clk_in);
    // single pulse per request
    check_value("rsp.ready", rsp.ready, 0);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic [3:0]  wstrb;
    logic [31:0] unused;
    wstrb = rand_bits(4);
    if (wstrb == 4'h0) begin
      wstrb = 4'hf;
    end
    bus_access(addr, data, wstrb, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bus_access(addr, 32'h0, 4'h0, data);
  endtask

  task automatic write_reg(input int idx, input logic [31:0] data);
    bus_write(addr_of(idx), data);
    if (write_mask(idx) != 32'h0) begin
      shadow[idx] = data & write_mask(idx);
    end
  endtask

  task automatic check_reg(input int idx);
    logic [31:0] d;
    bus_read(addr_of(idx), d);
    check_value($sformatf("rsp.rdata of register %0d", idx), d, expect_word(idx));
  endtask

  task automatic reg_op();
    int          idx;
    logic [31:0] data;
    logic [31:0] addr;
    logic [31:0] d;
    case (rand_bits(2))
      0: begin
        idx = rand_bits(4) % 10;
        data = rand_bits(32);
        // send and enable stay low here
        if (idx == stepper_pkg::reg_spi_config || idx == stepper_pkg::reg_angle_ctrl_lower) begin
          data[0] = 1'b0;
        end
        write_reg(idx, data);
      end
      1: check_reg(rand_bits(4) % 10);
      default: begin
        addr = addr_of(10 + rand_bits(4) % 6);
        if (rand_bits(1) == 1) begin
          addr = rand_bits(32) & 32'hffff_fffc;
          if (addr[31:28] == 4'h1) begin
            addr[31:28] = 4'h3;
          end
        end
        bus_write(addr, rand_bits(32));
        bus_read(addr, d);
        check_value("rsp.rdata outside the map", d, 0);
      end
    endcase
    check_value("leds", leds, shadow[stepper_pkg::reg_leds][7:0]);
  endtask

  task automatic run_frame(input logic [3:0] sel);
    logic [31:0] d;
    write_reg(stepper_pkg::reg_spi_tx_upper, rand_bits(32));
    write_reg(stepper_pkg::reg_spi_tx_lower, rand_bits(32));
    write_reg(stepper_pkg::reg_spi_config, {27'h0, sel, 1'b0});
    cs_expect = (sel < 12) ? ~(12'h001 << sel) : 12'hfff;
    cs_seen = 1'b0;
    sck_rises = 0;
    write_reg(stepper_pkg::reg_spi_config, {27'h0, sel, 1'b1});
    do begin
      bus_read(addr_of(stepper_pkg::reg_spi_status), d);
    end while (d[0] !== 1'b1);
    check_value("sck rising edges", sck_rises, SPI_BITS);
    check_value("cs_n selected line low", cs_seen, sel < 12);
    rx_model = {shadow[stepper_pkg::reg_spi_tx_upper][7:0], shadow[stepper_pkg::reg_spi_tx_lower]};
    check_reg(stepper_pkg::reg_spi_rx_upper);
    check_reg(stepper_pkg::reg_spi_rx_lower);
    // send is still high so no second frame may start
    sck_rises = 0;
    repeat (4 * CLK_DIV) @(negedge clk_in);
    check_value("sck rising edges with send held", sck_rises, 0);
    check_reg(stepper_pkg::reg_spi_status);
    cs_expect = 12'hfff;
  endtask

  task automatic run_move(input int count);
    logic [31:0] d;
    int          exp_gap;
    write_reg(stepper_pkg::reg_angle_ctrl_upper, 32'h0);
    write_reg(stepper_pkg::reg_angle_ctrl_lower, 32'(count) << 1);
    step_times.delete();
    write_reg(stepper_pkg::reg_angle_ctrl_lower, (32'(count) << 1) | 32'h1);
    do begin
      bus_read(addr_of(stepper_pkg::reg_angle_status), d);
    end while (d[0] !== 1'b1);
    check_value("step pulses", step_times.size(), count);
    for (int i = 1; i < step_times.size(); i++) begin
      exp_gap = START_PERIOD - RAMP * i;
      if (exp_gap < MIN_PERIOD) begin
        exp_gap = MIN_PERIOD;
      end
      check_value($sformatf("step gap %0d", i), step_times[i] - step_times[i-1], exp_gap);
    end
  endtask

  initial begin
    #(LIMIT_CYCLES * 100);
    $display("timeout, the run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("Some tests failed");
    $fatal(1, "watchdog expired");
  end

  initial begin
    logic [3:0] sel;
    clk_in = 1'b0;
    rst_n = 1'b0;
    req = '0;
    lfsr = 32'h1b51;
    rx_model = '0;
    cs_expect = 12'hfff;
    cs_seen = 1'b0;
    sck_rises = 0;
    cycle_count = 0;
    for (int i = 0; i < stepper_pkg::reg_count; i++) begin
      shadow[i] = 32'h0;
    end
    repeat (8) @(posedge clk_in);
    rst_n <= 1'b1;
    @(negedge clk_in);

    check_value("rsp.ready", rsp.ready, 0);
    check_value("cs_n", cs_n, 12'hfff);
    check_value("sck", sck, 0);
    check_value("mosi", mosi, 0);
    check_value("step", step, 0);
    check_value("leds", leds, 0);
    for (int i = 0; i < stepper_pkg::reg_count; i++) begin
      check_reg(i);
    end

    for (int i = 0; i < REG_OPS; i++) begin
      reg_op();
    end

    // last frame uses an index past the chip selects
    for (int i = 0; i < SPI_FRAMES; i++) begin
      if (i == SPI_FRAMES - 1) begin
        sel = 4'd12 + 4'(rand_bits(2));
      end else begin
        sel = 4'(rand_bits(4) % 12);
      end
      run_frame(sel);
    end

    for (int i = 0; i < MOVES; i++) begin
      run_move((i == 0) ? 0 : int'(rand_bits(5) % 21));
    end

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== design/stepper_periph.sv ====
`timescale 1ns/1ps

module stepper_periph #(
  parameter int CLK_DIV      = 4,
  parameter int START_PERIOD = 40,
  parameter int MIN_PERIOD   = 8,
  parameter int RAMP         = 4
) (
  input  logic                  clk_in,
  input  logic                  rst_n,
  input  stepper_pkg::bus_req_t req,
  output stepper_pkg::bus_rsp_t rsp,
  output logic [7:0]            leds,
  input  logic                  miso,
  output logic                  sck,
  output logic                  mosi,
  output logic [11:0]           cs_n,
  output logic                  step
);

  localparam int SPI_BITS = 40;
  localparam int CS_COUNT = 12;

  logic [stepper_pkg::reg_count-1:0]       wr_strobe;
  logic [stepper_pkg::reg_count-1:0][31:0] rd_words;

  logic [31:0]              leds_q;
  logic [31:0]              tx_upper_q;
  logic [31:0]              tx_lower_q;
  logic [31:0]              angle_upper_q;
  logic [31:0]              angle_lower_q;
  stepper_pkg::spi_cfg_t    spi_cfg;
  stepper_pkg::angle_ctrl_t angle_ctrl;
  logic [SPI_BITS-1:0]      rx_data;
  logic                     spi_ready;
  logic                     step_done;

  periph_decode u_decode (
    .clk_in   (clk_in),
    .rst_n    (rst_n),
    .req      (req),
    .rsp      (rsp),
    .wr_strobe(wr_strobe),
    .rd_words (rd_words)
  );

  io_register u_leds (
    .clk_in(clk_in),
    .rst_n (rst_n),
    .load  (wr_strobe[stepper_pkg::reg_leds]),
    .wdata (req.wdata),
    .q     (leds_q)
  );

  io_register u_tx_upper (
    .clk_in(clk_in),
    .rst_n (rst_n),
    .load  (wr_strobe[stepper_pkg::reg_spi_tx_upper]),
    .wdata (req.wdata),
    .q     (tx_upper_q)
  );

  io_register u_tx_lower (
    .clk_in(clk_in),
    .rst_n (rst_n),
    .load  (wr_strobe[stepper_pkg::reg_spi_tx_lower]),
    .wdata (req.wdata),
    .q     (tx_lower_q)
  );

  io_register #(
    .payload_t(stepper_pkg::spi_cfg_t)
  ) u_spi_cfg (
    .clk_in(clk_in),
    .rst_n (rst_n),
    .load  (wr_strobe[stepper_pkg::reg_spi_config]),
    .wdata (req.wdata),
    .q     (spi_cfg)
  );

  io_register u_angle_upper (
    .clk_in(clk_in),
    .rst_n (rst_n),
    .load  (wr_strobe[stepper_pkg::reg_angle_ctrl_upper]),
    .wdata (req.wdata),
    .q     (angle_upper_q)
  );

  io_register u_angle_lower (
    .clk_in(clk_in),
    .rst_n (rst_n),
    .load  (wr_strobe[stepper_pkg::reg_angle_ctrl_lower]),
    .wdata (req.wdata),
    .q     (angle_lower_q)
  );

  // enable is lower bit 0, the rest is the step count
  assign angle_ctrl = stepper_pkg::angle_ctrl_t'({angle_upper_q, angle_lower_q});

  spi_master #(
    .SPI_BITS(SPI_BITS),
    .CS_COUNT(CS_COUNT),
    .CLK_DIV (CLK_DIV)
  ) u_spi (
    .clk_in (clk_in),
    .rst_n  (rst_n),
    .tx_data({tx_upper_q[7:0], tx_lower_q}),
    .cfg    (spi_cfg),
    .miso   (miso),
    .rx_data(rx_data),
    .ready  (spi_ready),
    .sck    (sck),
    .mosi   (mosi),
    .cs_n   (cs_n)
  );

  step_ramp #(
    .START_PERIOD(START_PERIOD),
    .MIN_PERIOD  (MIN_PERIOD),
    .RAMP        (RAMP)
  ) u_step (
    .clk_in(clk_in),
    .rst_n (rst_n),
    .ctrl  (angle_ctrl),
    .step  (step),
    .done  (step_done)
  );

  // read-back words, status bits padded with zeros
  always_comb begin
    rd_words = '0;
    rd_words[stepper_pkg::reg_leds]             = leds_q;
    rd_words[stepper_pkg::reg_spi_tx_upper]     = tx_upper_q;
    rd_words[stepper_pkg::reg_spi_tx_lower]     = tx_lower_q;
    rd_words[stepper_pkg::reg_spi_rx_upper]     = {24'h0, rx_data[39:32]};
    rd_words[stepper_pkg::reg_spi_rx_lower]     = rx_data[31:0];
    rd_words[stepper_pkg::reg_spi_config]       = {27'h0, spi_cfg};
    rd_words[stepper_pkg::reg_spi_status]       = {31'h0, spi_ready};
    rd_words[stepper_pkg::reg_angle_ctrl_upper] = angle_upper_q;
    rd_words[stepper_pkg::reg_angle_ctrl_lower] = angle_lower_q;
    rd_words[stepper_pkg::reg_angle_status]     = {31'h0, step_done};
  end

  assign leds = leds_q[7:0];

endmodule

// ==== design/step_ramp.sv ====
`timescale 1ns/1ps

module step_ramp #(
  parameter int START_PERIOD = 40,
  parameter int MIN_PERIOD   = 8,
  parameter int RAMP         = 4
) (
  input  logic                     clk_in,
  input  logic                     rst_n,
  input  stepper_pkg::angle_ctrl_t ctrl,
  output logic                     step,
  output logic                     done
);

  localparam int PW = $clog2(START_PERIOD + 1);

  logic          en_q;
  logic          start;
  logic [62:0]   remaining;
  logic [PW-1:0] period;
  logic [PW-1:0] cnt;
  logic [PW-1:0] next_period;

  assign start = ctrl.enable && !en_q && done;

  // linear ramp, floored at the minimum period
  always_comb begin
    if (period >= PW'(MIN_PERIOD + RAMP)) begin
      next_period = period - PW'(RAMP);
    end else begin
      next_period = PW'(MIN_PERIOD);
    end
  end

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      en_q      <= 1'b0;
      step      <= 1'b0;
      done      <= 1'b1;
      remaining <= '0;
      period    <= '0;
      cnt       <= '0;
    end else begin
      en_q <= ctrl.enable;
      step <= 1'b0;
      if (done) begin
        // zero steps leaves done high
        if (start && ctrl.steps != '0) begin
          done      <= 1'b0;
          remaining <= ctrl.steps;
          period    <= PW'(START_PERIOD);
          cnt       <= PW'(START_PERIOD - 1);
        end
      end else if (remaining == '0) begin
        done <= 1'b1;
      end else if (cnt == '0) begin
        step      <= 1'b1;
        remaining <= remaining - 1'b1;
        period    <= next_period;
        cnt       <= next_period - 1'b1;
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

endmodule

// ==== design/spi_master.sv ====
`timescale 1ns/1ps

module spi_master #(
  parameter int SPI_BITS = 40,
  parameter int CS_COUNT = 12,
  parameter int CLK_DIV  = 4
) (
  input  logic                  clk_in,
  input  logic                  rst_n,
  input  logic [SPI_BITS-1:0]   tx_data,
  input  stepper_pkg::spi_cfg_t cfg,
  input  logic                  miso,
  output logic [SPI_BITS-1:0]   rx_data,
  output logic                  ready,
  output logic                  sck,
  output logic                  mosi,
  output logic [CS_COUNT-1:0]   cs_n
);

  localparam int DW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam int BW = $clog2(SPI_BITS + 1);

  logic                send_q;
  logic                start;
  logic [DW-1:0]       div_cnt;
  logic [BW-1:0]       bit_cnt;
  logic [SPI_BITS-1:0] shreg;
  logic [CS_COUNT-1:0] cs_dec_n;

  // new frame only on a fresh send edge while idle
  assign start = cfg.send && !send_q && ready;

  // out-of-range index leaves every line high
  always_comb begin
    cs_dec_n = '1;
    if (cfg.cs_sel < CS_COUNT) begin
      cs_dec_n[cfg.cs_sel] = 1'b0;
    end
  end

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      send_q  <= 1'b0;
      ready   <= 1'b1;
      sck     <= 1'b0;
      mosi    <= 1'b0;
      cs_n    <= '1;
      div_cnt <= '0;
      bit_cnt <= '0;
      shreg   <= '0;
      rx_data <= '0;
    end else begin
      send_q <= cfg.send;
      if (start) begin
        ready   <= 1'b0;
        cs_n    <= cs_dec_n;
        shreg   <= tx_data;
        // mode 0, first bit must be set up before the first rising edge
        mosi    <= tx_data[SPI_BITS-1];
        div_cnt <= '0;
        bit_cnt <= '0;
      end else if (!ready) begin
        if (div_cnt != DW'(CLK_DIV - 1)) begin
          div_cnt <= div_cnt + 1'b1;
        end else begin
          div_cnt <= '0;
          sck     <= !sck;
          if (!sck) begin
            // rising edge, sample into the freed low bit
            shreg   <= {shreg[SPI_BITS-2:0], miso};
            bit_cnt <= bit_cnt + 1'b1;
          end else if (bit_cnt == BW'(SPI_BITS)) begin
            // last falling edge closes the frame
            ready   <= 1'b1;
            cs_n    <= '1;
            mosi    <= 1'b0;
            rx_data <= shreg;
          end else begin
            mosi <= shreg[SPI_BITS-1];
          end
        end
      end
    end
  end

endmodule

// ==== design/periph_decode.sv ====
`timescale 1ns/1ps

module periph_decode (
  input  logic                                     clk_in,
  input  logic                                     rst_n,
  input  stepper_pkg::bus_req_t                    req,
  output stepper_pkg::bus_rsp_t                    rsp,
  output logic [stepper_pkg::reg_count-1:0]        wr_strobe,
  input  logic [stepper_pkg::reg_count-1:0][31:0]  rd_words
);

  localparam logic [stepper_pkg::reg_count-1:0] writable =
    (1 << stepper_pkg::reg_leds) |
    (1 << stepper_pkg::reg_spi_tx_upper) |
    (1 << stepper_pkg::reg_spi_tx_lower) |
    (1 << stepper_pkg::reg_spi_config) |
    (1 << stepper_pkg::reg_angle_ctrl_upper) |
    (1 << stepper_pkg::reg_angle_ctrl_lower);

  logic [29:0]           word_off;
  logic                  hit;
  logic                  is_write;
  logic                  start;
  logic                  busy;
  logic                  ready_q;
  logic [31:0]           rdata_q;
  stepper_pkg::reg_idx_e idx;

  // word offset from the window base, wraps for addresses below it
  assign word_off = req.addr[31:2] - stepper_pkg::periph_base[31:2];
  assign hit      = word_off < stepper_pkg::reg_count;
  assign idx      = stepper_pkg::reg_idx_e'(word_off[3:0]);
  assign is_write = req.wstrb != 4'b0000;

  // first cycle of a request only
  assign start = req.valid && !busy;

  always_comb begin
    wr_strobe = '0;
    if (start && is_write && hit && writable[idx]) begin
      wr_strobe[idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      busy    <= 1'b0;
      ready_q <= 1'b0;
      rdata_q <= '0;
    end else begin
      ready_q <= start;
      // held until the master lets go of valid
      if (!req.valid) begin
        busy <= 1'b0;
      end else if (start) begin
        busy <= 1'b1;
      end
      rdata_q <= (start && !is_write && hit) ? rd_words[idx] : 32'h0;
    end
  end

  assign rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

// ==== design/io_register.sv ====
`timescale 1ns/1ps

module io_register #(
  parameter type payload_t = logic [31:0]
) (
  input  logic        clk_in,
  input  logic        rst_n,
  input  logic        load,
  input  logic [31:0] wdata,
  output payload_t    q
);

  localparam int PW = $bits(payload_t);

  logic [PW-1:0] low_bits;

  // only the bits the payload can hold
  assign low_bits = wdata[PW-1:0];

  always_ff @(posedge clk_in or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (load) begin
      q <= payload_t'(low_bits);
    end
  end

endmodule

// ==== design/stepper_pkg.sv ====
package stepper_pkg;

  // peripheral window, one word per register
  localparam logic [31:0] periph_base = 32'h1000_0000;
  localparam int reg_count = 10;

  // word index inside the window
  typedef enum logic [3:0] {
    reg_leds             = 4'd0,
    reg_spi_tx_upper     = 4'd1,
    reg_spi_tx_lower     = 4'd2,
    reg_spi_rx_upper     = 4'd3,
    reg_spi_rx_lower     = 4'd4,
    reg_spi_config       = 4'd5,
    reg_spi_status       = 4'd6,
    reg_angle_ctrl_upper = 4'd7,
    reg_angle_ctrl_lower = 4'd8,
    reg_angle_status     = 4'd9
  } reg_idx_e;

  // native memory bus, master side
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } bus_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } bus_rsp_t;

  // send sits in bit 0
  typedef struct packed {
    logic [3:0] cs_sel;
    logic       send;
  } spi_cfg_t;

  // upper word and lower[31:1] form the step count
  typedef struct packed {
    logic [62:0] steps;
    logic        enable;
  } angle_ctrl_t;

endpackage
